/* hdl/noc_link_config.svh */
`ifndef NOC_LINK_CONFIG_SVH
`define NOC_LINK_CONFIG_SVH

//////////////////////////////
// core word fields
//////////////////////////////

`define NOC_ROUTE_W      5   // destination route
`define NOC_CODE_W       7   // command code passed through untouched
`define NOC_PAYLOAD_W    20  // split over two data flits

//////////////////////////////
// router side
//////////////////////////////

`define NOC_FLIT_DATA_W  10  // flit body with the tail bit on top

// flit buffer depths in powers of two
`define NOC_TX_FIFO_DEPTH 8
`define NOC_RX_FIFO_DEPTH 8

`endif

/* hdl/noc_link_pkg.sv */
`include "noc_link_config.svh"

package noc_link_pkg;

	// field types of a core word
	typedef logic [`NOC_ROUTE_W-1:0]     route_t;
	typedef logic [`NOC_CODE_W-1:0]      code_t;
	typedef logic [`NOC_PAYLOAD_W-1:0]   payload_t;

	// flit body without tail
	typedef logic [`NOC_FLIT_DATA_W-1:0] flit_data_t;

	// transmit side FSM
	typedef enum logic [2:0] {
		ST_IDLE, // no word held
		ST_HEAD, // header flit out
		ST_D0,   // code flit
		ST_D1,   // payload high half
		ST_D2    // payload low half with the tail
	} ser_state_t;

	// receive side FSM
	typedef enum logic [2:0] {
		DS_HEAD, // expecting a header
		DS_D0,   // expecting code
		DS_D1,   // expecting payload high
		DS_D2,   // expecting payload low
		DS_OUT   // word on the output with flits held off
	} des_state_t;

endpackage

/* hdl/noc_link_if.sv */
`timescale 1ns/1ps

//////////////////////////////
// core side word channel
//////////////////////////////

interface core_word_if;
	import noc_link_pkg::*;

	logic     valid;   // source has a word
	logic     ready;   // sink takes it
	route_t   route;
	code_t    code;
	payload_t payload;

	modport src (
		output valid, route, code, payload,
		input  ready
	);

	modport dst (
		input  valid, route, code, payload,
		output ready
	);
endinterface

//////////////////////////////
// router side flit channel
//////////////////////////////

interface flit_if;
	import noc_link_pkg::*;

	logic       valid;
	logic       ready;
	flit_data_t data;  // header or data body
	logic       tail;  // last flit of a packet

	modport src (
		output valid, data, tail,
		input  ready
	);

	modport dst (
		input  valid, data, tail,
		output ready
	);
endinterface

/* hdl/flit_fifo.sv */
`timescale 1ns/1ps

// first word fall through flit buffer
module flit_fifo #(
	parameter int DEPTH = 8  // power of two
) (
	input logic clk,
	input logic reset,
	flit_if.dst wr,
	flit_if.src rd
);
	import noc_link_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	if ((DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
		$error("flit_fifo DEPTH must be a power of two");
	end

	flit_data_t mem_data [DEPTH];  // flit bodies
	logic       mem_tail [DEPTH];  // matching tail bits

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;    // flits stored

	logic wr_fire;
	logic rd_fire;

	assign wr.ready = (count != CW'(DEPTH));
	assign rd.valid = (count != '0);
	assign rd.data  = mem_data[rd_ptr];  // head of queue without a register stage
	assign rd.tail  = mem_tail[rd_ptr];

	assign wr_fire = wr.valid && wr.ready;
	assign rd_fire = rd.valid && rd.ready;

	//////////////////////////////
	// pointers and fill count
	//////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_fire)
				wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
			if (rd_fire)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_fire, rd_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			mem_data[wr_ptr] <= wr.data;
			mem_tail[wr_ptr] <= wr.tail;
		end
	end

	// a write when full or a read when empty pushes the count out of range
	a_count_range: assert property (@(posedge clk) disable iff (reset)
		count <= CW'(DEPTH));

	// pointers meet only when empty or full
	a_ptr_match: assert property (@(posedge clk) disable iff (reset)
		(wr_ptr == rd_ptr) == ((count == '0) || (count == CW'(DEPTH))));

endmodule

/* hdl/flit_serializer.sv */
`timescale 1ns/1ps
`include "noc_link_config.svh"

// core word -> header + three data flits
// one word of lookahead lets same-route words share a packet
module flit_serializer (
	input logic         clk,
	input logic         reset,
	core_word_if.dst    word_in,
	flit_if.src         flit_out
);
	import noc_link_pkg::*;

	ser_state_t state;

	// word being cut into flits
	route_t   cur_route;
	code_t    cur_code;
	payload_t cur_payload;

	// lookahead word
	logic     nxt_valid;
	route_t   nxt_route;
	code_t    nxt_code;
	payload_t nxt_payload;

	logic word_fire;  // core word accepted
	logic flit_fire;  // flit taken by the FIFO
	logic take_nxt;   // accept into lookahead slot
	logic promote;    // lookahead becomes current on D2
	logic merge;      // next word continues this packet

	//////////////////////////////
	// handshakes
	//////////////////////////////

	assign word_fire = word_in.valid && word_in.ready;
	assign flit_fire = flit_out.valid && flit_out.ready;
	assign take_nxt  = word_fire && (state != ST_IDLE);
	assign promote   = flit_fire && (state == ST_D2) && nxt_valid;
	assign merge     = nxt_valid && (nxt_route == cur_route);

	// idle loads the current word directly and D2 freezes the tail decision
	always_comb begin
		case (state)
			ST_IDLE: word_in.ready = 1'b1;
			ST_D2:   word_in.ready = 1'b0;
			default: word_in.ready = !nxt_valid; // lookahead slot free
		endcase
	end

	//////////////////////////////
	// flit output mux
	//////////////////////////////

	assign flit_out.valid = (state != ST_IDLE);
	assign flit_out.tail  = (state == ST_D2) && !merge; // only D2 ever ends a packet

	always_comb begin
		case (state)
			ST_HEAD: flit_out.data = flit_data_t'(cur_route);  // zero extended
			ST_D0:   flit_out.data = flit_data_t'(cur_code);
			ST_D1:   flit_out.data = cur_payload[`NOC_PAYLOAD_W-1 -: `NOC_FLIT_DATA_W];
			ST_D2:   flit_out.data = cur_payload[`NOC_FLIT_DATA_W-1:0];
			default: flit_out.data = '0;
		endcase
	end

	//////////////////////////////
	// FSM
	//////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state     <= ST_IDLE;
			nxt_valid <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (word_fire) state <= ST_HEAD;
				ST_HEAD: if (flit_fire) state <= ST_D0;
				ST_D0:   if (flit_fire) state <= ST_D1;
				ST_D1:   if (flit_fire) state <= ST_D2;
				ST_D2: begin
					if (flit_fire) begin
						if (!nxt_valid)
							state <= ST_IDLE;
						else if (merge)
							state <= ST_D0;   // same route skips the header
						else
							state <= ST_HEAD; // new packet
					end
				end
				default: state <= ST_IDLE;
			endcase

			if (take_nxt)
				nxt_valid <= 1'b1;
			else if (promote)
				nxt_valid <= 1'b0;
		end
	end

	// current and lookahead word registers
	always_ff @(posedge clk) begin
		if (word_fire && (state == ST_IDLE)) begin
			cur_route   <= word_in.route;
			cur_code    <= word_in.code;
			cur_payload <= word_in.payload;
		end else if (promote) begin
			cur_route   <= nxt_route;
			cur_code    <= nxt_code;
			cur_payload <= nxt_payload;
		end
		if (take_nxt) begin
			nxt_route   <= word_in.route;
			nxt_code    <= word_in.code;
			nxt_payload <= word_in.payload;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// stalled flit must hold body and tail
	a_flit_stable: assert property (@(posedge clk) disable iff (reset)
		flit_out.valid && !flit_out.ready |=>
			flit_out.valid && $stable(flit_out.data) && $stable(flit_out.tail));

	// lookahead and tail decision stay frozen while D2 waits
	a_d2_lookahead_frozen: assert property (@(posedge clk) disable iff (reset)
		state == ST_D2 && !flit_fire |=> $stable(nxt_valid) && $stable(nxt_route));

endmodule

/* hdl/flit_deserializer.sv */
`timescale 1ns/1ps
`include "noc_link_config.svh"

// flit packets -> core words
// a D2 with tail clear means the packet goes on with the same route
module flit_deserializer (
	input logic       clk,
	input logic       reset,
	flit_if.dst       flit_in,
	core_word_if.src  word_out
);
	import noc_link_pkg::*;

	des_state_t state;

	// word under assembly doubles as the output register
	route_t     route_r;
	code_t      code_r;
	flit_data_t pay_hi;
	flit_data_t pay_lo;

	logic last_tail;  // tail seen on the latest D2

	logic flit_fire;
	logic word_fire;

	assign flit_fire = flit_in.valid && flit_in.ready;
	assign word_fire = word_out.valid && word_out.ready;

	//////////////////////////////
	// outputs
	//////////////////////////////

	assign flit_in.ready    = (state != DS_OUT);  // hold flits off while a word waits
	assign word_out.valid   = (state == DS_OUT);
	assign word_out.route   = route_r;
	assign word_out.code    = code_r;
	assign word_out.payload = {pay_hi, pay_lo};

	//////////////////////////////
	// FSM
	//////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state     <= DS_HEAD;
			last_tail <= 1'b1;
		end else begin
			case (state)
				DS_HEAD: if (flit_fire) state <= DS_D0;
				DS_D0:   if (flit_fire) state <= DS_D1;
				DS_D1:   if (flit_fire) state <= DS_D2;
				DS_D2: begin
					if (flit_fire) begin
						state     <= DS_OUT;
						last_tail <= flit_in.tail;
					end
				end
				DS_OUT: begin
					if (word_fire) begin
						if (last_tail)
							state <= DS_HEAD;  // packet closed
						else
							state <= DS_D0;    // merged packet keeps the route
					end
				end
				default: state <= DS_HEAD;
			endcase
		end
	end

	//////////////////////////////
	// field capture
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (flit_fire) begin
			case (state)
				DS_HEAD: route_r <= flit_in.data[`NOC_ROUTE_W-1:0];
				DS_D0:   code_r  <= flit_in.data[`NOC_CODE_W-1:0];
				DS_D1:   pay_hi  <= flit_in.data;
				DS_D2:   pay_lo  <= flit_in.data;
				default: ;
			endcase
		end
	end

	// header body is only a zero extended route
	a_header_upper_zero: assert property (@(posedge clk) disable iff (reset)
		state == DS_HEAD && flit_in.valid |->
			flit_in.data[`NOC_FLIT_DATA_W-1:`NOC_ROUTE_W] == '0);

endmodule

/* hdl/network_interface.sv */
`timescale 1ns/1ps
`include "noc_link_config.svh"

// core <-> router network interface
module network_interface (
	input  logic                    clk,
	input  logic                    reset,
	// core words to transmit
	input  logic                    word_in_valid,
	input  noc_link_pkg::route_t    word_in_route,
	input  noc_link_pkg::code_t     word_in_code,
	input  noc_link_pkg::payload_t  word_in_payload,
	output logic                    word_in_ready,
	// flits to the router
	output logic                    flit_out_valid,
	output noc_link_pkg::flit_data_t flit_out_data,
	output logic                    flit_out_tail,
	input  logic                    flit_out_ready,
	// flits from the router
	input  logic                    flit_in_valid,
	input  noc_link_pkg::flit_data_t flit_in_data,
	input  logic                    flit_in_tail,
	output logic                    flit_in_ready,
	// rebuilt core words
	output logic                    word_out_valid,
	output noc_link_pkg::route_t    word_out_route,
	output noc_link_pkg::code_t     word_out_code,
	output noc_link_pkg::payload_t  word_out_payload,
	input  logic                    word_out_ready
);

	core_word_if tx_word ();  // core -> serializer
	flit_if      tx_flit ();  // serializer -> tx FIFO
	flit_if      tx_out  ();  // tx FIFO -> router
	flit_if      rx_in   ();  // router -> rx FIFO
	flit_if      rx_flit ();  // rx FIFO -> deserializer
	core_word_if rx_word ();  // deserializer -> core

	//////////////////////////////
	// transmit path
	//////////////////////////////

	assign tx_word.valid   = word_in_valid;
	assign tx_word.route   = word_in_route;
	assign tx_word.code    = word_in_code;
	assign tx_word.payload = word_in_payload;
	assign word_in_ready   = tx_word.ready;

	flit_serializer i_ser (.clk, .reset, .word_in(tx_word), .flit_out(tx_flit));

	flit_fifo #(.DEPTH(`NOC_TX_FIFO_DEPTH)) i_tx_fifo (
		.clk, .reset, .wr(tx_flit), .rd(tx_out)
	);

	assign flit_out_valid = tx_out.valid;
	assign flit_out_data  = tx_out.data;
	assign flit_out_tail  = tx_out.tail;
	assign tx_out.ready   = flit_out_ready;

	//////////////////////////////
	// receive path
	//////////////////////////////

	assign rx_in.valid   = flit_in_valid;
	assign rx_in.data    = flit_in_data;
	assign rx_in.tail    = flit_in_tail;
	assign flit_in_ready = rx_in.ready;

	flit_fifo #(.DEPTH(`NOC_RX_FIFO_DEPTH)) i_rx_fifo (
		.clk, .reset, .wr(rx_in), .rd(rx_flit)
	);

	flit_deserializer i_des (.clk, .reset, .flit_in(rx_flit), .word_out(rx_word));

	assign word_out_valid   = rx_word.valid;
	assign word_out_route   = rx_word.route;
	assign word_out_code    = rx_word.code;
	assign word_out_payload = rx_word.payload;
	assign rx_word.ready    = word_out_ready;

endmodule

/* bench/network_interface_tb.sv */
`timescale 1ns/1ps
`include "noc_link_config.svh"

module network_interface_tb;
	import noc_link_pkg::*;

	localparam int FW          = `NOC_FLIT_DATA_W;  // tail sits at this index
	localparam int WORD_W      = `NOC_ROUTE_W + `NOC_CODE_W + `NOC_PAYLOAD_W;
	localparam int N_MERGE     = 6;   // same-route run in test 2
	localparam int N_RAND      = 60;  // words per random test
	localparam int TOTAL_WORDS = 1 + N_MERGE + 3 * N_RAND;
	localparam int MAX_CYCLES  = TOTAL_WORDS * 40 + 500;

	typedef logic [WORD_W-1:0] word_t;  // {route, code, payload}
	typedef logic [FW:0]       flit_t;  // {tail, body}

	logic       clk;
	logic       reset;
	logic       word_in_valid;
	route_t     word_in_route;
	code_t      word_in_code;
	payload_t   word_in_payload;
	logic       word_in_ready;
	logic       flit_out_valid;
	flit_data_t flit_out_data;
	logic       flit_out_tail;
	logic       flit_out_ready;
	logic       flit_in_valid;
	flit_data_t flit_in_data;
	logic       flit_in_tail;
	logic       flit_in_ready;
	logic       word_out_valid;
	route_t     word_out_route;
	code_t      word_out_code;
	payload_t   word_out_payload;
	logic       word_out_ready;

	logic [31:0] lfsr = 32'h9ad9f702;
	bit          rand_ready = 0;  // randomize both ready inputs
	bit          loopback = 0;    // flit_out feeds flit_in
	int          errors = 0;
	int          passed = 0;
	int          failed = 0;

	word_t sent_words[$];  // model of sent words in order
	word_t got_words[$];   // word_out or words parsed from flit_out
	flit_t tx_flits[$];    // every flit seen on flit_out
	flit_t rx_flits[$];    // flits waiting for flit_in

	network_interface i_dut (.*);

	initial begin : clock_gen
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// galois, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA3000000) : (lfsr >> 1);
		end
		return v;
	endfunction

	// route repeats half the time to provoke merging
	function automatic word_t rand_word(input route_t prev);
		route_t   r;
		code_t    c;
		payload_t p;
		r = (rand_bits(1) != 0) ? prev : route_t'(rand_bits(`NOC_ROUTE_W));
		c = code_t'(rand_bits(`NOC_CODE_W));
		p = payload_t'(rand_bits(`NOC_PAYLOAD_W));
		return {r, c, p};
	endfunction

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_word(input string sig, input route_t er, input code_t ec,
			input payload_t ep, input route_t gr, input code_t gc, input payload_t gp);
		if (gr !== er) begin
			$display("ERROR %0t %s_route exp %h got %h", $time, sig, er, gr);
			errors++;
		end
		if (gc !== ec) begin
			$display("ERROR %0t %s_code exp %h got %h", $time, sig, ec, gc);
			errors++;
		end
		if (gp !== ep) begin
			$display("ERROR %0t %s_payload exp %h got %h", $time, sig, ep, gp);
			errors++;
		end
	endtask

	task automatic check_flit(input flit_data_t ed, input logic et,
			input flit_data_t gd, input logic gt);
		if (gd !== ed) begin
			$display("ERROR %0t flit_out_data exp %h got %h", $time, ed, gd);
			errors++;
		end
		if (gt !== et) begin
			$display("ERROR %0t flit_out_tail exp %b got %b", $time, et, gt);
			errors++;
		end
	endtask

	task automatic check_bit(input string sig, input logic exp, input logic got);
		if (got !== exp) begin
			$display("ERROR %0t %s exp %b got %b", $time, sig, exp, got);
			errors++;
		end
	endtask

	task automatic check_count(input string sig, input int exp, input int got);
		if (got != exp) begin
			$display("ERROR %0t %s count exp %0d got %0d", $time, sig, exp, got);
			errors++;
		end
	endtask

	task automatic expect_flit(input int i, input flit_data_t ed, input logic et);
		flit_t f;
		f = tx_flits[i];
		check_flit(ed, et, f[FW-1:0], f[FW]);
	endtask

	task automatic compare_words(input string sig);
		route_t   er;
		code_t    ec;
		payload_t ep;
		route_t   gr;
		code_t    gc;
		payload_t gp;
		check_count({sig, " words"}, sent_words.size(), got_words.size());
		for (int i = 0; i < sent_words.size() && i < got_words.size(); i++) begin
			{er, ec, ep} = sent_words[i];
			{gr, gc, gp} = got_words[i];
			check_word(sig, er, ec, ep, gr, gc, gp);
		end
	endtask

	//////////////////////////////
	// flit stream parser
	//////////////////////////////

	// route carries over unless the last tail closed the packet
	task automatic parse_flits(input bit check);
		flit_t    f;
		route_t   r;
		code_t    c;
		payload_t p;
		bit       open;
		int       i;
		open = 0;
		i = 0;
		r = '0;
		got_words.delete();
		while (i + (open ? 3 : 4) <= tx_flits.size()) begin
			if (!open) begin
				f = tx_flits[i];
				r = route_t'(f[FW-1:0]);
				if (check)
					check_flit(flit_data_t'(r), 1'b0, f[FW-1:0], f[FW]);  // upper bits zero
				i++;
			end
			f = tx_flits[i];
			c = code_t'(f[FW-1:0]);
			if (check)
				check_flit(flit_data_t'(c), 1'b0, f[FW-1:0], f[FW]);
			f = tx_flits[i+1];
			p[`NOC_PAYLOAD_W-1 -: FW] = f[FW-1:0];
			if (check)
				check_flit(f[FW-1:0], 1'b0, f[FW-1:0], f[FW]);  // tail only on D2
			f = tx_flits[i+2];
			p[FW-1:0] = f[FW-1:0];
			open = !f[FW];
			i += 3;
			got_words.push_back({r, c, p});
		end
		if (check) begin
			check_count("flit_out flits", tx_flits.size(), i);
			if (open) begin
				$display("ERROR %0t flit stream ends inside an open packet", $time);
				errors++;
			end
		end
	endtask

	//////////////////////////////
	// drivers and monitors
	//////////////////////////////

	task automatic send_word(input word_t w);
		{word_in_route, word_in_code, word_in_payload} = w;
		word_in_valid = 1'b1;
		do
			@(posedge clk);
		while (!word_in_ready);
		#1;
		word_in_valid = 1'b0;
		sent_words.push_back(w);
	endtask

	task automatic send_random(input int n);
		word_t  w;
		route_t prev;
		int     gap;
		prev = '0;
		for (int k = 0; k < n; k++) begin
			w = rand_word(prev);
			prev = w[WORD_W-1 -: `NOC_ROUTE_W];
			send_word(w);
			gap = (rand_bits(1) != 0) ? 0 : int'(rand_bits(2));  // often back to back
			if (gap > 0) begin
				repeat (gap) @(posedge clk);
				#1;
			end
		end
	endtask

	// packets by the format rule with same-route runs merged at random
	task automatic build_rx_packets(input int n);
		route_t   r;
		code_t    c;
		payload_t p;
		route_t   prev;
		bit       open;
		open = 0;
		for (int k = 0; k < n; k++) begin
			prev = (k == 0) ? route_t'(0) : sent_words[k-1][WORD_W-1 -: `NOC_ROUTE_W];
			sent_words.push_back(rand_word(prev));
		end
		for (int k = 0; k < n; k++) begin
			{r, c, p} = sent_words[k];
			if (!open)
				rx_flits.push_back({1'b0, flit_data_t'(r)});
			rx_flits.push_back({1'b0, flit_data_t'(c)});
			rx_flits.push_back({1'b0, p[`NOC_PAYLOAD_W-1 -: FW]});
			open = (k + 1 < n) && (sent_words[k+1][WORD_W-1 -: `NOC_ROUTE_W] == r)
				&& (rand_bits(1) != 0);
			rx_flits.push_back({!open, p[FW-1:0]});
		end
	endtask

	initial begin : flit_driver
		flit_t f;
		logic  fire;
		forever begin
			@(posedge clk);
			fire = flit_in_valid && flit_in_ready;
			#1;
			if (fire)
				flit_in_valid = 1'b0;
			if (!flit_in_valid && rx_flits.size() > 0 && rand_bits(1) != 0) begin
				f = rx_flits.pop_front();
				{flit_in_tail, flit_in_data} = f;
				flit_in_valid = 1'b1;
			end
		end
	end

	initial begin : ready_driver
		forever begin
			@(posedge clk);
			#1;
			flit_out_ready = rand_ready ? (rand_bits(1) != 0) : 1'b1;
			word_out_ready = rand_ready ? (rand_bits(1) != 0) : 1'b1;
		end
	end

	always @(posedge clk) begin
		if (!reset && flit_out_valid && flit_out_ready) begin
			tx_flits.push_back({flit_out_tail, flit_out_data});
			if (loopback)
				rx_flits.push_back({flit_out_tail, flit_out_data});  // back into rx side
		end
		if (!reset && word_out_valid && word_out_ready)
			got_words.push_back({word_out_route, word_out_code, word_out_payload});
	end

	initial begin : watchdog
		#(MAX_CYCLES * 10);
		$display("timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic new_test();
		sent_words.delete();
		got_words.delete();
		tx_flits.delete();
		rx_flits.delete();
	endtask

	task automatic settle();
		repeat (20) @(posedge clk);
		#1;
	endtask

	task automatic end_test(input string name, input int err_start);
		if (errors == err_start) begin
			$display("test %s: ok", name);
			passed++;
		end else begin
			$display("test %s: %0d errors", name, errors - err_start);
			failed++;
		end
	endtask

	initial begin : main
		int       e0;
		word_t    w;
		route_t   r;
		code_t    c;
		payload_t p;
		reset = 1'b1;
		word_in_valid = 1'b0;
		word_in_route = '0;
		word_in_code = '0;
		word_in_payload = '0;
		flit_out_ready = 1'b1;
		flit_in_valid = 1'b0;
		flit_in_data = '0;
		flit_in_tail = 1'b0;
		word_out_ready = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		e0 = errors;  // handshake outputs out of reset
		check_bit("flit_out_valid", 1'b0, flit_out_valid);
		check_bit("word_out_valid", 1'b0, word_out_valid);
		check_bit("word_in_ready", 1'b1, word_in_ready);
		check_bit("flit_in_ready", 1'b1, flit_in_ready);
		end_test("reset_state", e0);

		e0 = errors;  // single word between idle gaps
		new_test();
		settle();
		w = rand_word('0);
		send_word(w);
		while (tx_flits.size() < 4)
			@(posedge clk);
		settle();
		{r, c, p} = w;
		check_count("flit_out flits", 4, tx_flits.size());
		expect_flit(0, flit_data_t'(r), 1'b0);
		expect_flit(1, flit_data_t'(c), 1'b0);
		expect_flit(2, p[`NOC_PAYLOAD_W-1 -: FW], 1'b0);
		expect_flit(3, p[FW-1:0], 1'b1);
		end_test("single_word", e0);

		e0 = errors;  // same-route run as one packet
		new_test();
		r = route_t'(rand_bits(`NOC_ROUTE_W));
		for (int k = 0; k < N_MERGE; k++) begin
			w = rand_word(r);
			w[WORD_W-1 -: `NOC_ROUTE_W] = r;
			send_word(w);
		end
		while (tx_flits.size() < 1 + 3 * N_MERGE)
			@(posedge clk);
		settle();
		check_count("flit_out flits", 1 + 3 * N_MERGE, tx_flits.size());
		expect_flit(0, flit_data_t'(r), 1'b0);
		for (int k = 0; k < N_MERGE; k++) begin
			{r, c, p} = sent_words[k];
			expect_flit(1 + 3 * k, flit_data_t'(c), 1'b0);
			expect_flit(2 + 3 * k, p[`NOC_PAYLOAD_W-1 -: FW], 1'b0);
			expect_flit(3 + 3 * k, p[FW-1:0], k == N_MERGE - 1);
		end
		end_test("merged_run", e0);

		e0 = errors;  // random transmit parsed back
		new_test();
		rand_ready = 1;
		send_random(N_RAND);
		do begin
			@(posedge clk);
			parse_flits(0);
		end while (got_words.size() < N_RAND);
		settle();
		parse_flits(1);
		compare_words("flit_out");
		end_test("random_tx", e0);

		e0 = errors;  // receive path from built packets
		new_test();
		build_rx_packets(N_RAND);
		while (got_words.size() < N_RAND)
			@(posedge clk);
		settle();
		compare_words("word_out");
		end_test("random_rx", e0);

		e0 = errors;  // flit_out looped into flit_in
		new_test();
		loopback = 1;
		send_random(N_RAND);
		while (got_words.size() < N_RAND)
			@(posedge clk);
		settle();
		compare_words("word_out");
		loopback = 0;
		end_test("loopback", e0);

		$display("tests ok %0d, tests failing %0d, check errors %0d", passed, failed, errors);
		if (failed == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* noc_link.f */
+incdir+hdl
hdl/noc_link_pkg.sv
hdl/noc_link_if.sv
hdl/flit_fifo.sv
hdl/flit_serializer.sv
hdl/flit_deserializer.sv
hdl/network_interface.sv
bench/network_interface_tb.sv

/* Bender.yml */
package:
  name: noc_link

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/noc_link_pkg.sv
      - hdl/noc_link_if.sv
      - hdl/flit_fifo.sv
      - hdl/flit_serializer.sv
      - hdl/flit_deserializer.sv
      - hdl/network_interface.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/network_interface_tb.sv
